// File: hdl/ctrl_pkg.sv
/* Shared constants and the instruction word type for the RV32 decode stage
   RV32I + M + machine-mode SYSTEM only; F/D, A and RV64 encodings are not defined */
`default_nettype none

package ctrl_pkg;

  localparam int INSTR_W    = 32;
  localparam int ALU_CTRL_W = 4;
  localparam int WB_SEL_W   = 3;
  localparam int IMM_SEL_W  = 3;
  localparam int MD_OP_W    = 3;  // Carries funct3 of MUL/DIV/REM

  // Base opcodes, bits [6:0]
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ALU operation codes
  localparam logic [ALU_CTRL_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_CTRL_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_CTRL_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_CTRL_W-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_CTRL_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_CTRL_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_CTRL_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_CTRL_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_CTRL_W-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_CTRL_W-1:0] ALU_AND  = 4'd9;

  // Write-back source
  localparam logic [WB_SEL_W-1:0] WB_ALU = 3'd0;
  localparam logic [WB_SEL_W-1:0] WB_MEM = 3'd1;
  localparam logic [WB_SEL_W-1:0] WB_PC4 = 3'd2;  // Link address
  localparam logic [WB_SEL_W-1:0] WB_CSR = 3'd3;
  localparam logic [WB_SEL_W-1:0] WB_MD  = 3'd4;  // Mul/div unit

  // Immediate formats
  localparam logic [IMM_SEL_W-1:0] IMM_I = 3'd0;
  localparam logic [IMM_SEL_W-1:0] IMM_S = 3'd1;
  localparam logic [IMM_SEL_W-1:0] IMM_B = 3'd2;
  localparam logic [IMM_SEL_W-1:0] IMM_U = 3'd3;
  localparam logic [IMM_SEL_W-1:0] IMM_J = 3'd4;

  localparam logic [6:0]  FUNCT7_MULDIV = 7'b0000001;
  localparam logic [11:0] IMM12_ECALL   = 12'h000;
  localparam logic [11:0] IMM12_EBREAK  = 12'h001;
  localparam logic [11:0] IMM12_MRET    = 12'h302;

  // One word, two views; field ranges follow instruction bit numbers
  typedef union packed {
    struct packed {
      logic [INSTR_W-1:25] funct7;
      logic [24:20]        rs2;
      logic [19:15]        rs1;
      logic [14:12]        funct3;
      logic [11:7]         rd;
      logic [6:0]          opcode;
    } r;
    struct packed {
      logic [INSTR_W-1:20] imm12;  // Also CSR address / SYSTEM function
      logic [19:15]        rs1;
      logic [14:12]        funct3;
      logic [11:7]         rd;
      logic [6:0]          opcode;
    } i;
  } instr_u;

endpackage

`default_nettype wire

// File: hdl/alu_op_decode.sv
/* ALU and M-extension operation decode from funct3/funct7
   Caller qualifies with is_reg_op; opcode is never seen here */
`default_nettype none

module alu_op_decode (
  input  logic [2:0]                       funct3,
  input  logic [6:0]                       funct7,
  input  logic                             is_reg_op,   // OP form, else OP-IMM
  output logic [ctrl_pkg::ALU_CTRL_W-1:0]  alu_ctrl,
  output logic                             mul_div_en,
  output logic [ctrl_pkg::MD_OP_W-1:0]     mul_div_op
);

  import ctrl_pkg::*;

  logic [ALU_CTRL_W-1:0] base_ctrl;  // Plain integer op
  logic                  is_md;

  assign is_md = is_reg_op && (funct7 == FUNCT7_MULDIV);

  always_comb begin
    case (funct3)
      3'b000: begin
        if (is_reg_op && funct7[5])
          base_ctrl = ALU_SUB;       // Only R-type has SUB
        else
          base_ctrl = ALU_ADD;
      end
      3'b001: base_ctrl = ALU_SLL;
      3'b010: base_ctrl = ALU_SLT;
      3'b011: base_ctrl = ALU_SLTU;
      3'b100: base_ctrl = ALU_XOR;
      3'b101: begin
        if (funct7[5])               // SRAI uses imm[10] as well
          base_ctrl = ALU_SRA;
        else
          base_ctrl = ALU_SRL;
      end
      3'b110: base_ctrl = ALU_OR;
      3'b111: base_ctrl = ALU_AND;
      default: base_ctrl = ALU_ADD;
    endcase
  end

  // M-unit takes over; ALU just passes operands
  assign mul_div_en = is_md;
  assign mul_div_op = is_md ? funct3 : '0;  // MUL..REMU in funct3 order
  assign alu_ctrl   = is_md ? ALU_ADD : base_ctrl;

endmodule

`default_nettype wire

// File: hdl/system_decode.sv
/* SYSTEM-opcode field decode for Zicsr, ECALL, EBREAK and MRET
   Caller qualifies with the opcode; WFI, SRET and others count as illegal */
`default_nettype none

module system_decode (
  input  logic [2:0]  funct3,
  input  logic [11:0] imm12,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rd,
  output logic        csr_we,
  output logic        csr_src,    // 1 = zimm in rs1 field
  output logic        is_csr,
  output logic        mret,
  output logic        sys_legal
);

  import ctrl_pkg::*;

  logic priv_form;  // funct3 zero with rs1/rd zero
  logic is_ecall;
  logic is_ebreak;

  // funct3 of 4 is reserved in SYSTEM
  assign is_csr = (funct3 != 3'b000) && (funct3 != 3'b100);

  assign csr_we  = is_csr;          // Write suppression for rs1=x0 left to the core
  assign csr_src = is_csr & funct3[2];

  assign priv_form = (funct3 == 3'b000) && (rs1 == 5'd0) && (rd == 5'd0);

  assign is_ecall  = priv_form && (imm12 == IMM12_ECALL);
  assign is_ebreak = priv_form && (imm12 == IMM12_EBREAK);
  assign mret      = priv_form && (imm12 == IMM12_MRET);

  // Anything not matched above traps as illegal
  assign sys_legal = is_csr | is_ecall | is_ebreak | mret;

endmodule

`default_nettype wire

// File: hdl/main_control.sv
/* Combinational main control for RV32IM plus machine-mode SYSTEM
   Unlisted opcodes, including F/D, A and RV64 forms, raise only illegal_inst */
`default_nettype none

module main_control (
  input  ctrl_pkg::instr_u                 instr,
  output logic                             reg_write,
  output logic                             mem_read,
  output logic                             mem_write,
  output logic                             branch,
  output logic                             jump,
  output logic                             alu_src,     // 1 = immediate operand
  output logic                             csr_we,
  output logic                             csr_src,
  output logic                             mul_div_en,
  output logic                             illegal_inst,
  output logic [ctrl_pkg::ALU_CTRL_W-1:0]  alu_ctrl,
  output logic [ctrl_pkg::WB_SEL_W-1:0]    wb_sel,
  output logic [ctrl_pkg::IMM_SEL_W-1:0]   imm_sel,
  output logic [ctrl_pkg::MD_OP_W-1:0]     mul_div_op
);

  import ctrl_pkg::*;

  logic                  is_reg_op;
  logic [ALU_CTRL_W-1:0] op_alu_ctrl;
  logic                  op_md_en;
  logic [MD_OP_W-1:0]    op_md_op;
  logic                  sys_csr_we;
  logic                  sys_csr_src;
  logic                  sys_is_csr;
  logic                  sys_mret;
  logic                  sys_legal;

  assign is_reg_op = (instr.r.opcode == OP_OP);

  alu_op_decode i_alu_op_decode (
    .funct3     (instr.r.funct3),
    .funct7     (instr.r.funct7),
    .is_reg_op  (is_reg_op),
    .alu_ctrl   (op_alu_ctrl),
    .mul_div_en (op_md_en),
    .mul_div_op (op_md_op)
  );

  system_decode i_system_decode (
    .funct3    (instr.i.funct3),
    .imm12     (instr.i.imm12),
    .rs1       (instr.i.rs1),
    .rd        (instr.i.rd),
    .csr_we    (sys_csr_we),
    .csr_src   (sys_csr_src),
    .is_csr    (sys_is_csr),
    .mret      (sys_mret),
    .sys_legal (sys_legal)
  );

  always_comb begin
    // All-zero defaults
    reg_write    = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    branch       = 1'b0;
    jump         = 1'b0;
    alu_src      = 1'b0;
    csr_we       = 1'b0;
    csr_src      = 1'b0;
    mul_div_en   = 1'b0;
    illegal_inst = 1'b0;
    alu_ctrl     = ALU_ADD;
    wb_sel       = WB_ALU;
    imm_sel      = IMM_I;
    mul_div_op   = '0;

    case (instr.r.opcode)
      OP_LUI, OP_AUIPC: begin      // 0 + imm or PC + imm, chosen in the datapath
        reg_write = 1'b1;
        alu_src   = 1'b1;
        imm_sel   = IMM_U;
      end
      OP_JAL: begin
        reg_write = 1'b1;
        jump      = 1'b1;
        wb_sel    = WB_PC4;
        imm_sel   = IMM_J;
      end
      OP_JALR: begin               // Target is rs1 + imm
        reg_write = 1'b1;
        jump      = 1'b1;
        alu_src   = 1'b1;
        wb_sel    = WB_PC4;
      end
      OP_BRANCH: begin
        branch   = 1'b1;
        alu_ctrl = ALU_SUB;        // Compare via subtract
        imm_sel  = IMM_B;
      end
      OP_LOAD: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        alu_src   = 1'b1;          // Address = rs1 + offset
        wb_sel    = WB_MEM;
      end
      OP_STORE: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
        imm_sel   = IMM_S;
      end
      OP_IMM: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        alu_ctrl  = op_alu_ctrl;
      end
      OP_OP: begin
        reg_write  = 1'b1;
        alu_ctrl   = op_alu_ctrl;
        mul_div_en = op_md_en;
        mul_div_op = op_md_op;
        wb_sel     = op_md_en ? WB_MD : WB_ALU;
      end
      OP_FENCE: ;                  // No-op here, no caches to order
      OP_SYSTEM: begin
        if (sys_legal) begin
          reg_write = sys_is_csr;  // Old CSR value to rd
          csr_we    = sys_csr_we;
          csr_src   = sys_csr_src;
          wb_sel    = sys_is_csr ? WB_CSR : WB_ALU;
          jump      = sys_mret;    // Return through mepc
        end else begin
          illegal_inst = 1'b1;
        end
      end
      default: illegal_inst = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/ctrl_stage.sv
/* One-entry valid/ready register for the decoded control set
   Full throughput with out_ready high; payload clears on reset as well */
`default_nettype none

module ctrl_stage (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  output logic                             in_ready,
  input  logic                             dec_reg_write,
  input  logic                             dec_mem_read,
  input  logic                             dec_mem_write,
  input  logic                             dec_branch,
  input  logic                             dec_jump,
  input  logic                             dec_alu_src,
  input  logic                             dec_csr_we,
  input  logic                             dec_csr_src,
  input  logic                             dec_mul_div_en,
  input  logic                             dec_illegal_inst,
  input  logic [ctrl_pkg::ALU_CTRL_W-1:0]  dec_alu_ctrl,
  input  logic [ctrl_pkg::WB_SEL_W-1:0]    dec_wb_sel,
  input  logic [ctrl_pkg::IMM_SEL_W-1:0]   dec_imm_sel,
  input  logic [ctrl_pkg::MD_OP_W-1:0]     dec_mul_div_op,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic                             reg_write,
  output logic                             mem_read,
  output logic                             mem_write,
  output logic                             branch,
  output logic                             jump,
  output logic                             alu_src,
  output logic                             csr_we,
  output logic                             csr_src,
  output logic                             mul_div_en,
  output logic                             illegal_inst,
  output logic [ctrl_pkg::ALU_CTRL_W-1:0]  alu_ctrl,
  output logic [ctrl_pkg::WB_SEL_W-1:0]    wb_sel,
  output logic [ctrl_pkg::IMM_SEL_W-1:0]   imm_sel,
  output logic [ctrl_pkg::MD_OP_W-1:0]     mul_div_op
);

  logic accept;

  assign in_ready = !out_valid || out_ready;  // Empty, or slot drains this edge
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid    <= 1'b0;
      reg_write    <= 1'b0;
      mem_read     <= 1'b0;
      mem_write    <= 1'b0;
      branch       <= 1'b0;
      jump         <= 1'b0;
      alu_src      <= 1'b0;
      csr_we       <= 1'b0;
      csr_src      <= 1'b0;
      mul_div_en   <= 1'b0;
      illegal_inst <= 1'b0;
      alu_ctrl     <= '0;
      wb_sel       <= '0;
      imm_sel      <= '0;
      mul_div_op   <= '0;
    end else if (accept) begin
      out_valid    <= 1'b1;
      reg_write    <= dec_reg_write;
      mem_read     <= dec_mem_read;
      mem_write    <= dec_mem_write;
      branch       <= dec_branch;
      jump         <= dec_jump;
      alu_src      <= dec_alu_src;
      csr_we       <= dec_csr_we;
      csr_src      <= dec_csr_src;
      mul_div_en   <= dec_mul_div_en;
      illegal_inst <= dec_illegal_inst;
      alu_ctrl     <= dec_alu_ctrl;
      wb_sel       <= dec_wb_sel;
      imm_sel      <= dec_imm_sel;
      mul_div_op   <= dec_mul_div_op;
    end else if (out_ready) begin
      out_valid <= 1'b0;  // Taken, nothing behind it
    end
  end

endmodule

`default_nettype wire

// File: hdl/decode_top.sv
/* RV32 decode-control stage, instruction in and control set out
   One cycle latency, one instruction per cycle while out_ready stays high */
`default_nettype none

module decode_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  output logic                             in_ready,
  input  ctrl_pkg::instr_u                 instr,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic                             reg_write,
  output logic                             mem_read,
  output logic                             mem_write,
  output logic                             branch,
  output logic                             jump,
  output logic                             alu_src,
  output logic                             csr_we,
  output logic                             csr_src,
  output logic                             mul_div_en,
  output logic                             illegal_inst,
  output logic [ctrl_pkg::ALU_CTRL_W-1:0]  alu_ctrl,
  output logic [ctrl_pkg::WB_SEL_W-1:0]    wb_sel,
  output logic [ctrl_pkg::IMM_SEL_W-1:0]   imm_sel,
  output logic [ctrl_pkg::MD_OP_W-1:0]     mul_div_op
);

  import ctrl_pkg::*;

  // Combinational decode, before the register
  logic                  dec_reg_write;
  logic                  dec_mem_read;
  logic                  dec_mem_write;
  logic                  dec_branch;
  logic                  dec_jump;
  logic                  dec_alu_src;
  logic                  dec_csr_we;
  logic                  dec_csr_src;
  logic                  dec_mul_div_en;
  logic                  dec_illegal_inst;
  logic [ALU_CTRL_W-1:0] dec_alu_ctrl;
  logic [WB_SEL_W-1:0]   dec_wb_sel;
  logic [IMM_SEL_W-1:0]  dec_imm_sel;
  logic [MD_OP_W-1:0]    dec_mul_div_op;

  main_control i_main_control (
    .instr        (instr),
    .reg_write    (dec_reg_write),
    .mem_read     (dec_mem_read),
    .mem_write    (dec_mem_write),
    .branch       (dec_branch),
    .jump         (dec_jump),
    .alu_src      (dec_alu_src),
    .csr_we       (dec_csr_we),
    .csr_src      (dec_csr_src),
    .mul_div_en   (dec_mul_div_en),
    .illegal_inst (dec_illegal_inst),
    .alu_ctrl     (dec_alu_ctrl),
    .wb_sel       (dec_wb_sel),
    .imm_sel      (dec_imm_sel),
    .mul_div_op   (dec_mul_div_op)
  );

  ctrl_stage i_ctrl_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .dec_reg_write    (dec_reg_write),
    .dec_mem_read     (dec_mem_read),
    .dec_mem_write    (dec_mem_write),
    .dec_branch       (dec_branch),
    .dec_jump         (dec_jump),
    .dec_alu_src      (dec_alu_src),
    .dec_csr_we       (dec_csr_we),
    .dec_csr_src      (dec_csr_src),
    .dec_mul_div_en   (dec_mul_div_en),
    .dec_illegal_inst (dec_illegal_inst),
    .dec_alu_ctrl     (dec_alu_ctrl),
    .dec_wb_sel       (dec_wb_sel),
    .dec_imm_sel      (dec_imm_sel),
    .dec_mul_div_op   (dec_mul_div_op),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .reg_write        (reg_write),
    .mem_read         (mem_read),
    .mem_write        (mem_write),
    .branch           (branch),
    .jump             (jump),
    .alu_src          (alu_src),
    .csr_we           (csr_we),
    .csr_src          (csr_src),
    .mul_div_en       (mul_div_en),
    .illegal_inst     (illegal_inst),
    .alu_ctrl         (alu_ctrl),
    .wb_sel           (wb_sel),
    .imm_sel          (imm_sel),
    .mul_div_op       (mul_div_op)
  );

endmodule

`default_nettype wire

// File: tests/decode_sva.sv
/* Handshake assertions for ctrl_stage, attached by bind
   payload is the registered control set packed into one vector */
`default_nettype none

module decode_sva (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic in_ready,
  input logic out_valid,
  input logic out_ready,
  input logic [10 + ctrl_pkg::ALU_CTRL_W + ctrl_pkg::WB_SEL_W
               + ctrl_pkg::IMM_SEL_W + ctrl_pkg::MD_OP_W - 1:0] payload
);

  timeunit 1ns;
  timeprecision 100ps;

  // Empty one cycle after any reset edge
  a_reset_clears: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  // Stalled output must not move
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(payload)))
    else $error("output changed or dropped while stalled");

  // Accepted word shows up one cycle later
  a_accept_presents: assert property (@(posedge clk) disable iff (!rst_n)
      (in_valid && in_ready) |=> out_valid)
    else $error("accepted word not presented in the next cycle");

endmodule

bind ctrl_stage decode_sva i_decode_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .payload   ({reg_write, mem_read, mem_write, branch, jump, alu_src, csr_we, csr_src,
               mul_div_en, illegal_inst, alu_ctrl, wb_sel, imm_sel, mul_div_op})
);

`default_nettype wire

// File: tests/tb_decode_top.sv
/* Directed testbench for decode_top, expected controls built from the RV32IM decode rules
   Inputs change on the falling edge and outputs are sampled there; stops at the first error */
`default_nettype none

module tb_decode_top;

  timeunit 1ns;
  timeprecision 100ps;

  import ctrl_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int N_STREAM       = 40;
  localparam int N_INSTR        = 8 + 32 + 8 + 7 + 5 + 2 + N_STREAM;  // All tests together
  localparam int TIMEOUT_CYCLES = N_INSTR * 4 + 100;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_ready;
  instr_u                instr;
  logic                  out_valid;
  logic                  out_ready;
  logic                  reg_write;
  logic                  mem_read;
  logic                  mem_write;
  logic                  branch;
  logic                  jump;
  logic                  alu_src;
  logic                  csr_we;
  logic                  csr_src;
  logic                  mul_div_en;
  logic                  illegal_inst;
  logic [ALU_CTRL_W-1:0] alu_ctrl;
  logic [WB_SEL_W-1:0]   wb_sel;
  logic [IMM_SEL_W-1:0]  imm_sel;
  logic [MD_OP_W-1:0]    mul_div_op;

  // Expected control set of the word under check
  logic                  exp_reg_write;
  logic                  exp_mem_read;
  logic                  exp_mem_write;
  logic                  exp_branch;
  logic                  exp_jump;
  logic                  exp_alu_src;
  logic                  exp_csr_we;
  logic                  exp_csr_src;
  logic                  exp_mul_div_en;
  logic                  exp_illegal_inst;
  logic [ALU_CTRL_W-1:0] exp_alu_ctrl;
  logic [WB_SEL_W-1:0]   exp_wb_sel;
  logic [IMM_SEL_W-1:0]  exp_imm_sel;
  logic [MD_OP_W-1:0]    exp_mul_div_op;
  logic [INSTR_W-1:0]    cur_word;
  string                 test_name;

  decode_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .instr        (instr),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .reg_write    (reg_write),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .branch       (branch),
    .jump         (jump),
    .alu_src      (alu_src),
    .csr_we       (csr_we),
    .csr_src      (csr_src),
    .mul_div_en   (mul_div_en),
    .illegal_inst (illegal_inst),
    .alu_ctrl     (alu_ctrl),
    .wb_sel       (wb_sel),
    .imm_sel      (imm_sel),
    .mul_div_op   (mul_div_op)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic report_value(input string field, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s: %s expected %0h, actual %0h (instr %08h)",
             test_name, field, exp, act, cur_word);
    abort_run();
  endtask

  task automatic check_bit(input string field, input logic exp, input logic act);
    if (act !== exp) report_value(field, 32'(exp), 32'(act));
  endtask

  task automatic check_alu(input logic [ALU_CTRL_W-1:0] exp, input logic [ALU_CTRL_W-1:0] act);
    if (act !== exp) report_value("alu_ctrl", 32'(exp), 32'(act));
  endtask

  task automatic check_wb(input logic [WB_SEL_W-1:0] exp, input logic [WB_SEL_W-1:0] act);
    if (act !== exp) report_value("wb_sel", 32'(exp), 32'(act));
  endtask

  task automatic check_imm(input logic [IMM_SEL_W-1:0] exp, input logic [IMM_SEL_W-1:0] act);
    if (act !== exp) report_value("imm_sel", 32'(exp), 32'(act));
  endtask

  task automatic check_mdop(input logic [MD_OP_W-1:0] exp, input logic [MD_OP_W-1:0] act);
    if (act !== exp) report_value("mul_div_op", 32'(exp), 32'(act));
  endtask

  function automatic logic [INSTR_W-1:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // funct3 order of the base ALU ops, alt = funct7 bit 5
  function automatic logic [ALU_CTRL_W-1:0] expected_alu(input logic [2:0] f3, input logic alt,
      input logic is_op);
    case (f3)
      3'd0:    return (is_op && alt) ? ALU_SUB : ALU_ADD;  // No SUBI
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;              // SRAI too
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic logic is_known_op(input logic [6:0] op);
    return op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE,
                      OP_IMM, OP_OP, OP_FENCE, OP_SYSTEM};
  endfunction

  function automatic logic [6:0] random_base_op(input int k);
    case (k)
      0:       return OP_LUI;
      1:       return OP_AUIPC;
      2:       return OP_JAL;
      3:       return OP_JALR;
      4:       return OP_BRANCH;
      5:       return OP_LOAD;
      6:       return OP_STORE;
      7:       return OP_IMM;
      8:       return OP_OP;
      default: return OP_FENCE;
    endcase
  endfunction

  task automatic build_expected(input logic [INSTR_W-1:0] w);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic        priv_ok;
    op    = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    imm12 = w[31:20];
    priv_ok = (f3 == 3'd0) && (w[19:15] == 5'd0) && (w[11:7] == 5'd0) &&
              (imm12 inside {IMM12_ECALL, IMM12_EBREAK, IMM12_MRET});
    {exp_reg_write, exp_mem_read, exp_mem_write, exp_branch, exp_jump} = '0;
    {exp_alu_src, exp_csr_we, exp_csr_src, exp_mul_div_en, exp_illegal_inst} = '0;
    exp_alu_ctrl   = ALU_ADD;
    exp_wb_sel     = WB_ALU;
    exp_imm_sel    = IMM_I;
    exp_mul_div_op = '0;
    case (op)
      OP_LUI, OP_AUIPC: {exp_reg_write, exp_alu_src, exp_imm_sel} = {2'b11, IMM_U};
      OP_JAL: {exp_reg_write, exp_jump, exp_wb_sel, exp_imm_sel} = {2'b11, WB_PC4, IMM_J};
      OP_JALR: {exp_reg_write, exp_jump, exp_alu_src, exp_wb_sel} = {3'b111, WB_PC4};
      OP_BRANCH: {exp_branch, exp_alu_ctrl, exp_imm_sel} = {1'b1, ALU_SUB, IMM_B};
      OP_LOAD: {exp_reg_write, exp_mem_read, exp_alu_src, exp_wb_sel} = {3'b111, WB_MEM};
      OP_STORE: {exp_mem_write, exp_alu_src, exp_imm_sel} = {2'b11, IMM_S};
      OP_IMM: begin
        exp_reg_write = 1'b1;
        exp_alu_src   = 1'b1;
        exp_alu_ctrl  = expected_alu(f3, f7[5], 1'b0);
      end
      OP_OP: begin
        exp_reg_write = 1'b1;
        if (f7 == FUNCT7_MULDIV) begin                     // M extension
          exp_mul_div_en = 1'b1;
          exp_mul_div_op = f3;
          exp_wb_sel     = WB_MD;
        end else begin
          exp_alu_ctrl = expected_alu(f3, f7[5], 1'b1);
        end
      end
      OP_FENCE: ;
      OP_SYSTEM: begin
        if (f3 != 3'd0 && f3 != 3'd4) begin                // Zicsr
          {exp_reg_write, exp_csr_we, exp_wb_sel} = {2'b11, WB_CSR};
          exp_csr_src = f3[2];
        end else if (priv_ok) begin
          exp_jump = (imm12 == IMM12_MRET);
        end else begin
          exp_illegal_inst = 1'b1;
        end
      end
      default: exp_illegal_inst = 1'b1;
    endcase
  endtask

  task automatic compare_outputs(input logic [INSTR_W-1:0] w);
    cur_word = w;
    build_expected(w);
    check_bit("reg_write", exp_reg_write, reg_write);
    check_bit("mem_read", exp_mem_read, mem_read);
    check_bit("mem_write", exp_mem_write, mem_write);
    check_bit("branch", exp_branch, branch);
    check_bit("jump", exp_jump, jump);
    check_bit("alu_src", exp_alu_src, alu_src);
    check_bit("csr_we", exp_csr_we, csr_we);
    check_bit("csr_src", exp_csr_src, csr_src);
    check_bit("mul_div_en", exp_mul_div_en, mul_div_en);
    check_bit("illegal_inst", exp_illegal_inst, illegal_inst);
    check_alu(exp_alu_ctrl, alu_ctrl);
    check_wb(exp_wb_sel, wb_sel);
    check_imm(exp_imm_sel, imm_sel);
    check_mdop(exp_mul_div_op, mul_div_op);
  endtask

  // One word through the stage, out_ready assumed high
  task automatic send_and_compare(input logic [INSTR_W-1:0] w);
    @(negedge clk);
    instr    = w;
    in_valid = 1'b1;
    while (!in_ready) @(negedge clk);
    @(negedge clk);                       // Accepted on the edge in between
    in_valid = 1'b0;
    cur_word = w;
    check_bit("out_valid one cycle after accept", 1'b1, out_valid);
    compare_outputs(w);
  endtask

  task automatic base_opcodes();
    test_name = "base_opcodes";
    send_and_compare(32'h123450b7);       // lui x1, 0x12345
    send_and_compare(32'h00001117);       // auipc x2, 1
    send_and_compare(32'h008000ef);       // jal x1, +8
    send_and_compare(32'h000280e7);       // jalr x1, 0(x5)
    send_and_compare(32'h00208463);       // beq x1, x2, +8
    send_and_compare(32'h0040a183);       // lw x3, 4(x1)
    send_and_compare(32'h0020a423);       // sw x2, 8(x1)
    send_and_compare(32'h0ff0000f);       // fence
  endtask

  task automatic alu_codes();
    logic [6:0] f7;
    test_name = "alu_codes";
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int alt = 0; alt < 2; alt++) begin
        f7 = (alt != 0) ? 7'h20 : 7'h00;
        send_and_compare(encode_r(f7, 5'd3, 5'd2, 3'(f3), 5'd1, OP_IMM));
        send_and_compare(encode_r(f7, 5'd3, 5'd2, 3'(f3), 5'd1, OP_OP));
      end
    end
  endtask

  task automatic muldiv_ops();
    test_name = "muldiv_ops";
    for (int f3 = 0; f3 < 8; f3++) begin  // MUL .. REMU
      send_and_compare(encode_r(FUNCT7_MULDIV, 5'd7, 5'd6, 3'(f3), 5'd5, OP_OP));
      check_bit("mul_div_en", 1'b1, mul_div_en);
      check_wb(WB_MD, wb_sel);
    end
  endtask

  task automatic system_ops();
    test_name = "system_ops";
    send_and_compare(encode_r(7'h18, 5'd0, 5'd5, 3'd1, 5'd6, OP_SYSTEM));  // csrrw mstatus
    check_wb(WB_CSR, wb_sel);
    send_and_compare(encode_r(7'h18, 5'd0, 5'd8, 3'd6, 5'd7, OP_SYSTEM));  // csrrsi mstatus
    check_bit("csr_src", 1'b1, csr_src);
    send_and_compare(32'h30200073);       // mret
    check_bit("jump", 1'b1, jump);
    send_and_compare(32'h00000073);       // ecall
    send_and_compare(32'h00100073);       // ebreak
    send_and_compare(32'h00004073);       // Reserved funct3
    send_and_compare(32'h10500073);       // wfi, not supported
    check_bit("illegal_inst", 1'b1, illegal_inst);
  endtask

  task automatic illegal_opcodes();
    logic [6:0] op;
    test_name = "illegal_opcodes";
    send_and_compare(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'b0111011));  // OP-32
    send_and_compare(encode_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3, 7'b0101111));  // AMO
    send_and_compare(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'b1010011));  // OP-FP
    send_and_compare(encode_r(7'h00, 5'd0, 5'd1, 3'd2, 5'd3, 7'b0000111));  // LOAD-FP
    do
      op = 7'($urandom_range(127, 0));
    while (is_known_op(op));
    send_and_compare(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, op));
    check_bit("illegal_inst", 1'b1, illegal_inst);
  endtask

  task automatic backpressure();
    logic [INSTR_W-1:0] first;
    logic [INSTR_W-1:0] second;
    test_name = "backpressure";
    first  = 32'h123450b7;                // lui
    second = 32'h0020a423;                // sw
    @(negedge clk);
    out_ready = 1'b0;
    check_bit("idle out_valid", 1'b0, out_valid);
    check_bit("idle in_ready", 1'b1, in_ready);
    instr    = first;
    in_valid = 1'b1;
    @(negedge clk);
    instr = second;                       // Offered while stalled
    repeat (3) begin
      check_bit("stalled out_valid", 1'b1, out_valid);
      check_bit("stalled in_ready", 1'b0, in_ready);
      compare_outputs(first);
      @(negedge clk);
    end
    out_ready = 1'b1;                     // Drain first, take second
    @(negedge clk);
    in_valid = 1'b0;
    check_bit("out_valid after release", 1'b1, out_valid);
    compare_outputs(second);
  endtask

  task automatic random_stream();
    logic [INSTR_W-1:0] words[$];
    logic [INSTR_W-1:0] w;
    int                 sent;
    int                 got;
    test_name = "random_stream";
    for (int i = 0; i < N_STREAM; i++) begin
      w      = $urandom;
      w[6:0] = random_base_op($urandom_range(9, 0));
      words.push_back(w);
    end
    sent = 0;
    got  = 0;
    while (got < N_STREAM) begin
      @(negedge clk);
      out_ready = ($urandom_range(3, 0) != 0);  // Stall about one cycle in four
      in_valid  = (sent < N_STREAM);
      if (sent < N_STREAM) instr = words[sent];
      #1;                                        // in_ready follows out_ready
      if (out_valid && out_ready) begin
        compare_outputs(words[got]);
        got++;
      end
      if (in_valid && in_ready) sent++;
    end
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b1;
    check_bit("out_valid after last word", 1'b0, out_valid);  // Nothing extra
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    abort_run();
  end

  initial begin
    void'($urandom(32'h140f));
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    instr     = '0;
    cur_word  = '0;
    test_name = "reset";
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("out_valid after reset", 1'b0, out_valid);
    base_opcodes();
    alu_codes();
    muldiv_ops();
    system_ops();
    illegal_opcodes();
    backpressure();
    random_stream();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hdl/ctrl_pkg.sv
hdl/alu_op_decode.sv
hdl/system_decode.sv
hdl/main_control.sv
hdl/ctrl_stage.sv
hdl/decode_top.sv
tests/decode_sva.sv
tests/tb_decode_top.sv

// File: Makefile
SIM        := verilator
TOP        := tb_decode_top
FILELIST   := project.f
FLAGS      := --binary --assert
LINT_FLAGS := --lint-only --timing --assert -Wall
BUILD      := obj_dir
PASS_MSG   := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./$(BUILD)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
